// ==== block_reg_file.sv ====
// Per-block register array, one entry per cartridge block with one write and one read port
`timescale 1ns/1ps

module block_reg_file #(
    parameter int     NUM_BLOCKS  = cart_pkg::NUM_BLOCKS_DEFAULT,
    parameter type    entry_t     = logic,
    parameter entry_t RESET_VALUE = entry_t'(0)
) (
    input  logic                cpu_bus,
    input  logic                rst_n,
    input  logic                we,
    input  cart_pkg::block_id_t wr_id,
    input  entry_t              wdata,
    input  cart_pkg::block_id_t rd_id,
    output entry_t              rdata
);

    // One register per cartridge block so each block keeps its own mapping
    entry_t regs [NUM_BLOCKS];

    always_ff @(posedge cpu_bus) begin
        if (!rst_n) begin
            // Every block comes out of reset with the same mapping
            for (int i = 0; i < NUM_BLOCKS; i++) begin
                regs[i] <= RESET_VALUE;
            end
        end else if (we) begin
            regs[wr_id] <= wdata;
        end
    end

    // Read is combinational, a write shows up here from the next edge
    assign rdata = regs[rd_id];

    // A block id past the array would silently drop the write
    a_wr_id_in_range : assert property (@(posedge cpu_bus) disable iff (!rst_n)
        we |-> (int'(wr_id) < NUM_BLOCKS))
    else $error("register write to block %0d beyond %0d blocks", wr_id, NUM_BLOCKS);

endmodule

// ==== cart_addr_xlate.sv ====
// Address translator, forms ROM and SRAM addresses from the page registers and drives the memory selects
`timescale 1ns/1ps

module cart_addr_xlate (
    input  logic                                        cpu_bus,
    input  cart_pkg::cpu_bus_t                          cpu_req,
    input  cart_pkg::block_info_t                       blk,
    input  logic                                        cs,
    input  logic                                        mode_rtype,
    input  cart_pkg::bank_t [cart_pkg::NUM_PAGES-1:0]   bank_rd,
    input  logic [cart_pkg::NUM_PAGES-1:0]              sram_en_rd,
    output cart_pkg::mapper_out_t                       mem
);
    import cart_pkg::*;

    // Blocks above 2 KB of SRAM get the 8 KB window, smaller ones 2 KB
    localparam logic [SRAM_SIZE_W-1:0] SRAM_SMALL_KB = 16'd2;
    localparam int SRAM_BIG_W   = 13;
    localparam int SRAM_SMALL_W = 11;

    logic      page;
    bank_t     bank_sel;
    logic      sram_en;
    mem_addr_t rom_addr;
    mem_addr_t sram_addr;
    logic      rom_valid;
    logic      ram_cs;
    logic      sram_cs;

    // Address bit 15 tells the two 16 KB pages apart
    assign page = cpu_req.addr[15];

    // R-Type pins the lower page to a fixed bank, ASCII16 uses its register
    always_comb begin
        if (page) begin
            bank_sel = bank_rd[1];
        end else if (mode_rtype) begin
            bank_sel = RTYPE_FIXED_BANK;
        end else begin
            bank_sel = bank_rd[0];
        end
    end

    assign sram_en = sram_en_rd[page];

    // ROM address is the bank on top of the 16 KB page offset
    assign rom_addr = mem_addr_t'({bank_sel, cpu_req.addr[PAGE_OFS_W-1:0]});

    // The SRAM image is small, so the page offset is simply truncated
    assign sram_addr = (blk.sram_size > SRAM_SMALL_KB)
                     ? mem_addr_t'(cpu_req.addr[SRAM_BIG_W-1:0])
                     : mem_addr_t'(cpu_req.addr[SRAM_SMALL_W-1:0]);

    // Reads past the end of the ROM image must not reach the memory
    assign rom_valid = (rom_addr < mem_addr_t'(blk.rom_size));

    // ROM is read-only, SRAM answers reads and writes
    assign ram_cs  = cs & ~sram_en & cpu_req.rd & rom_valid;
    assign sram_cs = cs & sram_en & (cpu_req.rd | cpu_req.wr);

    assign mem.ram_cs  = ram_cs;
    assign mem.sram_cs = sram_cs;

    // SRAM is only writable through page 1, page 0 keeps it read-only
    assign mem.rnw = ~(sram_cs & cpu_req.wr & page);

    // The address is parked at all ones while the slot is not selected
    assign mem.addr = cs ? (sram_en ? sram_addr : rom_addr) : '1;

    // The page SRAM enable keeps ROM and SRAM exclusive on the memory side
    a_selects_exclusive : assert property (@(posedge cpu_bus)
        !(mem.ram_cs && mem.sram_cs))
    else $error("ROM and SRAM selected together at %h", cpu_req.addr);

    // An unselected slot leaves the memory idle with the parked address
    a_idle_when_unselected : assert property (@(posedge cpu_bus)
        !cs |-> (mem.addr == '1) && !mem.ram_cs && !mem.sram_cs && mem.rnw)
    else $error("memory not idle while slot is unselected");

endmodule

// ==== cart_mapper_ctrl.sv ====
// Mapper control, decodes chip select, mode and page and turns CPU writes into register strobes
`timescale 1ns/1ps

module cart_mapper_ctrl (
    input  logic                  cpu_bus,
    input  logic                  rst_n,
    input  cart_pkg::cpu_bus_t    cpu_req,
    input  cart_pkg::block_info_t blk,
    output logic                  cs,
    output logic                  mode_rtype,
    output logic                  page,
    output cart_pkg::reg_wr_t     reg_wr
);
    import cart_pkg::*;

    // ASCII16 bank register windows, matched on addr[15:11]
    // Page 0 sits at 0x6000-0x67FF and page 1 at 0x7000-0x77FF
    localparam logic [4:0] ASCII16_P0_WIN = 5'b01100;
    localparam logic [4:0] ASCII16_P1_WIN = 5'b01110;

    // R-Type has a single bank register at 0x7000-0x7FFF, matched on addr[15:12]
    localparam logic [3:0] RTYPE_P1_WIN = 4'b0111;

    // R-Type bank masks, the narrow one applies when data bit 4 is set
    localparam bank_t RTYPE_MASK_WIDE   = 8'h1F;
    localparam bank_t RTYPE_MASK_NARROW = 8'h17;

    logic  in_window;
    logic  mapper_en;
    logic  wr_hit;
    logic  sram_exists;
    logic  sram_code;
    logic  ascii_p0_hit;
    logic  ascii_p1_hit;
    logic  ascii_page_sel;
    logic  rtype_hit;
    bank_t rtype_bank;

    // Bits 15 and 14 differ only inside 0x4000-0xBFFF
    assign in_window = ^cpu_req.addr[15:14];

    // Only the two supported mapper kinds answer on the bus
    assign mapper_en  = (blk.typ == MAPPER_ASCII16) || (blk.typ == MAPPER_RTYPE);
    assign mode_rtype = (blk.typ == MAPPER_RTYPE);

    assign cs   = in_window & mapper_en & cpu_req.mreq;
    assign page = cpu_req.addr[15];

    // A register write is a selected access with both write strobes up
    assign wr_hit = cs & cpu_req.wr & cpu_req.req;

    // The SRAM code is only honoured when the block actually has SRAM
    assign sram_exists = (blk.sram_size != '0);
    assign sram_code   = (cpu_req.data == SRAM_ENABLE_CODE) && sram_exists;

    assign ascii_p0_hit = (cpu_req.addr[15:11] == ASCII16_P0_WIN);
    assign ascii_p1_hit = (cpu_req.addr[15:11] == ASCII16_P1_WIN);

    // The two ASCII16 windows differ in addr bit 12 only
    assign ascii_page_sel = cpu_req.addr[12];

    assign rtype_hit  = (cpu_req.addr[15:12] == RTYPE_P1_WIN);
    assign rtype_bank = cpu_req.data & (cpu_req.data[4] ? RTYPE_MASK_NARROW : RTYPE_MASK_WIDE);

    always_comb begin
        // Nothing is written unless a qualified access hits a register window
        reg_wr = '0;
        if (wr_hit) begin
            if (mode_rtype) begin
                // Only the upper page is banked in R-Type mode, SRAM is never touched
                if (rtype_hit) begin
                    reg_wr.bank_we[1] = 1'b1;
                    reg_wr.bank_val   = rtype_bank;
                end
            end else if (ascii_p0_hit || ascii_p1_hit) begin
                // Every ASCII16 write updates the SRAM enable of its page
                reg_wr.sram_we[ascii_page_sel] = 1'b1;
                reg_wr.bank_val                = cpu_req.data;
                if (sram_code) begin
                    reg_wr.sram_val = 1'b1;
                end else begin
                    // Any other value is a bank number and maps ROM back in
                    reg_wr.sram_val                = 1'b0;
                    reg_wr.bank_we[ascii_page_sel] = 1'b1;
                end
            end
        end
    end

    // A single CPU write touches the registers of one page at most
    a_one_page_per_write : assert property (@(posedge cpu_bus) disable iff (!rst_n)
        $onehot0({reg_wr.bank_we[1] | reg_wr.sram_we[1],
                  reg_wr.bank_we[0] | reg_wr.sram_we[0]}))
    else $error("register writes hit both pages in one cycle");

    // The bus is expected to stay quiet while the register files are being reset
    a_no_write_in_reset : assert property (@(posedge cpu_bus)
        !rst_n |-> (reg_wr.bank_we == '0) && (reg_wr.sram_we == '0))
    else $error("register write strobe raised during reset");

endmodule

// ==== cart_mapper_tb.sv ====
// Testbench for the cartridge mapper, applies a table of bus accesses and then a random idle phase
`timescale 1ns/1ps

module cart_mapper_tb;
    import cart_pkg::*;

    localparam realtime CLK_PERIOD   = 40.0;
    localparam realtime SETTLE       = 5.0;
    localparam int      RESET_CYCLES = 5;
    localparam int      RAND_CYCLES  = 40;

    localparam bit RD = 1'b0;
    localparam bit WR = 1'b1;

    // ROM image sizes in bytes, the edge size ends exactly at 0x24010
    localparam logic [ROM_SIZE_W-1:0] ROM_512K = 25'h0080000;
    localparam logic [ROM_SIZE_W-1:0] ROM_128K = 25'h0020000;
    localparam logic [ROM_SIZE_W-1:0] ROM_EDGE = 25'h0024010;

    // Parked address of an unselected slot
    localparam mem_addr_t IDLE = 27'h7FFFFFF;

    // One table entry, the access to drive and what the memory side must show
    typedef struct {
        bit          is_wr;
        logic [15:0] addr;
        logic [7:0]  data;
        block_info_t blk;
        logic        exp_ram;
        logic        exp_sram;
        logic        exp_rnw;
        mem_addr_t   exp_addr;
    } row_t;

    logic        cpu_bus;
    logic        rst_n;
    cpu_bus_t    cpu_req;
    block_info_t blk;
    mapper_out_t mem;

    row_t        rows[$];
    block_info_t cur_blk;
    int          errors;
    int          checks;
    integer      seed;
    bit          table_built;
    realtime     timeout_ns;

    tb_clock #(
        .PERIOD (CLK_PERIOD)
    ) clk_gen (
        .clk (cpu_bus)
    );

    cart_mapper_top #(
        .NUM_BLOCKS (2)
    ) dut0 (
        .cpu_bus (cpu_bus),
        .rst_n   (rst_n),
        .cpu_req (cpu_req),
        .blk     (blk),
        .mem     (mem)
    );

    // Compare one observed value with its expected value and log any difference
    task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    // Block descriptor used by the table rows that follow
    task automatic use_block(input mapper_type_e typ, input block_id_t id,
                             input logic [ROM_SIZE_W-1:0] rom, input logic [15:0] sram);
        cur_blk.typ       = typ;
        cur_blk.id        = id;
        cur_blk.rom_size  = rom;
        cur_blk.sram_size = sram;
    endtask

    task automatic add_row(input bit is_wr, input logic [15:0] addr, input logic [7:0] data,
                           input logic ram, input logic sram, input logic rnw,
                           input mem_addr_t exp_addr);
        row_t r;
        r.is_wr    = is_wr;
        r.addr     = addr;
        r.data     = data;
        r.blk      = cur_blk;
        r.exp_ram  = ram;
        r.exp_sram = sram;
        r.exp_rnw  = rnw;
        r.exp_addr = exp_addr;
        rows.push_back(r);
    endtask

    // Expected values follow the access rules, ROM address is bank * 0x4000 plus offset
    task automatic build_table();
        // Reset state, every bank is 0 and accesses outside the window stay idle
        use_block(MAPPER_ASCII16, 1'b0, ROM_512K, 16'd8);
        //      op  addr      data   ram   sram  rnw   addr
        add_row(RD, 16'h4000, 8'h00, 1'b1, 1'b0, 1'b1, 27'h0000000);
        add_row(RD, 16'h8123, 8'h00, 1'b1, 1'b0, 1'b1, 27'h0000123);
        add_row(RD, 16'h1234, 8'h00, 1'b0, 1'b0, 1'b1, IDLE);
        add_row(RD, 16'hC000, 8'h00, 1'b0, 1'b0, 1'b1, IDLE);
        use_block(MAPPER_NONE, 1'b0, ROM_512K, 16'd8);
        add_row(RD, 16'h4010, 8'h00, 1'b0, 1'b0, 1'b1, IDLE);

        // ASCII16 banking of block 0, a write shows the old bank in its own cycle
        use_block(MAPPER_ASCII16, 1'b0, ROM_512K, 16'd8);
        add_row(WR, 16'h6000, 8'h05, 1'b0, 1'b0, 1'b1, 27'h0002000);
        add_row(WR, 16'h7000, 8'h09, 1'b0, 1'b0, 1'b1, 27'h0017000);
        add_row(RD, 16'h4010, 8'h00, 1'b1, 1'b0, 1'b1, 27'h0014010);
        add_row(RD, 16'h8010, 8'h00, 1'b1, 1'b0, 1'b1, 27'h0024010);

        // Block 1 gets its own banks while block 0 keeps 5 and 9
        use_block(MAPPER_ASCII16, 1'b1, ROM_512K, 16'd8);
        add_row(WR, 16'h6000, 8'h03, 1'b0, 1'b0, 1'b1, 27'h0002000);
        add_row(WR, 16'h7000, 8'h0C, 1'b0, 1'b0, 1'b1, 27'h000F000);
        add_row(RD, 16'h4010, 8'h00, 1'b1, 1'b0, 1'b1, 27'h000C010);
        add_row(RD, 16'hA000, 8'h00, 1'b1, 1'b0, 1'b1, 27'h0032000);
        use_block(MAPPER_ASCII16, 1'b0, ROM_512K, 16'd8);
        add_row(RD, 16'h4010, 8'h00, 1'b1, 1'b0, 1'b1, 27'h0014010);
        add_row(RD, 16'h8010, 8'h00, 1'b1, 1'b0, 1'b1, 27'h0024010);

        // ROM range, the address is still shown when the select is held off
        use_block(MAPPER_ASCII16, 1'b0, ROM_128K, 16'd8);
        add_row(RD, 16'h8010, 8'h00, 1'b0, 1'b0, 1'b1, 27'h0024010);
        add_row(RD, 16'h4010, 8'h00, 1'b1, 1'b0, 1'b1, 27'h0014010);
        use_block(MAPPER_ASCII16, 1'b0, ROM_EDGE, 16'd8);
        add_row(RD, 16'h8010, 8'h00, 1'b0, 1'b0, 1'b1, 27'h0024010);
        add_row(RD, 16'h800F, 8'h00, 1'b1, 1'b0, 1'b1, 27'h002400F);

        // SRAM in page 1, 13 bit address for 8 KB and 11 bit for 2 KB
        use_block(MAPPER_ASCII16, 1'b0, ROM_512K, 16'd8);
        add_row(WR, 16'h7000, 8'h10, 1'b0, 1'b0, 1'b1, 27'h0017000);
        add_row(RD, 16'hB234, 8'h00, 1'b0, 1'b1, 1'b1, 27'h0001234);
        use_block(MAPPER_ASCII16, 1'b0, ROM_512K, 16'd2);
        add_row(RD, 16'hB234, 8'h00, 1'b0, 1'b1, 1'b1, 27'h0000234);
        use_block(MAPPER_ASCII16, 1'b0, ROM_512K, 16'd8);
        add_row(WR, 16'hB234, 8'h5A, 1'b0, 1'b1, 1'b0, 27'h0001234);
        add_row(RD, 16'h4010, 8'h00, 1'b1, 1'b0, 1'b1, 27'h0014010);

        // SRAM in page 0 is readable but rnw stays high on writes
        add_row(WR, 16'h6000, 8'h10, 1'b0, 1'b0, 1'b1, 27'h0016000);
        add_row(RD, 16'h4567, 8'h00, 1'b0, 1'b1, 1'b1, 27'h0000567);
        add_row(WR, 16'h4567, 8'h77, 1'b0, 1'b1, 1'b1, 27'h0000567);
        add_row(WR, 16'h6000, 8'h05, 1'b0, 1'b1, 1'b1, 27'h0000000);
        add_row(RD, 16'h4010, 8'h00, 1'b1, 1'b0, 1'b1, 27'h0014010);

        // Without SRAM the enable code is an ordinary bank number
        use_block(MAPPER_ASCII16, 1'b0, ROM_512K, 16'd0);
        add_row(WR, 16'h7000, 8'h10, 1'b0, 1'b0, 1'b1, 27'h0017000);
        add_row(RD, 16'h8010, 8'h00, 1'b1, 1'b0, 1'b1, 27'h0040010);
        add_row(RD, 16'hB234, 8'h00, 1'b1, 1'b0, 1'b1, 27'h0043234);

        // R-Type, page 0 is pinned to bank 0x0F and page 1 takes masked writes
        use_block(MAPPER_RTYPE, 1'b1, ROM_512K, 16'd0);
        add_row(RD, 16'h4010, 8'h00, 1'b1, 1'b0, 1'b1, 27'h003C010);
        add_row(WR, 16'h7800, 8'h35, 1'b0, 1'b0, 1'b1, 27'h003F800);
        add_row(RD, 16'h8010, 8'h00, 1'b1, 1'b0, 1'b1, 27'h0054010);
        add_row(WR, 16'h7800, 8'h0B, 1'b0, 1'b0, 1'b1, 27'h003F800);
        add_row(RD, 16'h8010, 8'h00, 1'b1, 1'b0, 1'b1, 27'h002C010);
        add_row(WR, 16'h6000, 8'h22, 1'b0, 1'b0, 1'b1, 27'h003E000);
        add_row(RD, 16'h4010, 8'h00, 1'b1, 1'b0, 1'b1, 27'h003C010);
        add_row(RD, 16'h8010, 8'h00, 1'b1, 1'b0, 1'b1, 27'h002C010);
    endtask

    // Drive one row on the falling edge and check the memory side once it settles
    task automatic apply_row(input int idx);
        row_t r;
        r = rows[idx];
        @(negedge cpu_bus);
        cpu_req.addr = r.addr;
        cpu_req.data = r.data;
        cpu_req.mreq = 1'b1;
        cpu_req.rd   = ~r.is_wr;
        cpu_req.wr   = r.is_wr;
        cpu_req.req  = 1'b1;
        blk          = r.blk;
        #(SETTLE);
        check_val(32'(mem.ram_cs), 32'(r.exp_ram), $sformatf("row %0d ram_cs", idx));
        check_val(32'(mem.sram_cs), 32'(r.exp_sram), $sformatf("row %0d sram_cs", idx));
        check_val(32'(mem.rnw), 32'(r.exp_rnw), $sformatf("row %0d rnw", idx));
        check_val(32'(mem.addr), 32'(r.exp_addr), $sformatf("row %0d addr", idx));
        // The register takes the write on the rising edge, wr drops on the next falling edge
        if (r.is_wr) begin
            @(negedge cpu_bus);
            cpu_req.wr  = 1'b0;
            cpu_req.req = 1'b0;
        end
    endtask

    // Random accesses that are never selected, the memory side must stay parked
    task automatic check_idle_random(input int n);
        logic [31:0] raw;
        raw = $random(seed);
        @(negedge cpu_bus);
        cpu_req.addr      = raw[15:0];
        cpu_req.data      = raw[23:16];
        cpu_req.rd        = raw[24];
        cpu_req.wr        = raw[25];
        cpu_req.req       = raw[26];
        cpu_req.mreq      = 1'b1;
        blk.id            = raw[27];
        blk.typ           = raw[28] ? MAPPER_RTYPE : MAPPER_ASCII16;
        blk.rom_size      = ROM_512K;
        blk.sram_size     = raw[29] ? 16'd8 : 16'd0;
        // Knock out exactly one of the three select conditions
        case (raw[31:30])
            2'd0:    cpu_req.addr[14] = cpu_req.addr[15];
            2'd1:    cpu_req.mreq = 1'b0;
            2'd2:    blk.typ = MAPPER_NONE;
            default: blk.typ = mapper_type_e'({1'b1, raw[18:16]});
        endcase
        #(SETTLE);
        check_val(32'(mem.ram_cs), 32'h0, $sformatf("random %0d ram_cs", n));
        check_val(32'(mem.sram_cs), 32'h0, $sformatf("random %0d sram_cs", n));
        check_val(32'(mem.rnw), 32'h1, $sformatf("random %0d rnw", n));
        check_val(32'(mem.addr), 32'(IDLE), $sformatf("random %0d addr", n));
    endtask

    initial begin
        rst_n       = 1'b0;
        cpu_req     = '0;
        blk         = '0;
        cur_blk     = '0;
        errors      = 0;
        checks      = 0;
        seed        = 32'h60ae;
        table_built = 1'b0;
        build_table();
        timeout_ns  = real'(rows.size() + RAND_CYCLES + RESET_CYCLES) * CLK_PERIOD * 4.0;
        table_built = 1'b1;

        repeat (RESET_CYCLES) @(posedge cpu_bus);
        @(negedge cpu_bus);
        rst_n = 1'b1;

        for (int i = 0; i < rows.size(); i++) begin
            apply_row(i);
        end
        for (int n = 0; n < RAND_CYCLES; n++) begin
            check_idle_random(n);
        end

        $display("Run complete: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Ends a run that stalls well past the expected length of the table and random phase
    initial begin
        wait (table_built);
        #(timeout_ns);
        $display("Watchdog expired at %0t, the simulation hung before finishing", $time);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== cart_mapper_top.f ====
cart_pkg.sv
cart_mapper_ctrl.sv
block_reg_file.sv
cart_addr_xlate.sv
cart_mapper_top.sv
tb_clock.sv
cart_mapper_tb.sv

// ==== cart_mapper_top.sv ====
// Cartridge mapper top level, connects the control, the page register files and the translator
`timescale 1ns/1ps

module cart_mapper_top #(
    parameter int NUM_BLOCKS = cart_pkg::NUM_BLOCKS_DEFAULT
) (
    input  logic                  cpu_bus,
    input  logic                  rst_n,
    input  cart_pkg::cpu_bus_t    cpu_req,
    input  cart_pkg::block_info_t blk,
    output cart_pkg::mapper_out_t mem
);
    import cart_pkg::*;

    logic                 cs;
    logic                 mode_rtype;
    reg_wr_t              reg_wr;
    bank_t [NUM_PAGES-1:0] bank_rd;
    logic [NUM_PAGES-1:0] sram_en_rd;

    // Access decode and register write strobes
    // The translator takes the page straight from addr bit 15
    cart_mapper_ctrl u_ctrl (
        .cpu_bus    (cpu_bus),
        .rst_n      (rst_n),
        .cpu_req    (cpu_req),
        .blk        (blk),
        .cs         (cs),
        .mode_rtype (mode_rtype),
        .page       (),
        .reg_wr     (reg_wr)
    );

    // Bank number of page 0 for every block
    block_reg_file #(
        .NUM_BLOCKS  (NUM_BLOCKS),
        .entry_t     (bank_t),
        .RESET_VALUE (bank_t'(0))
    ) bank_p0 (
        .cpu_bus (cpu_bus),
        .rst_n   (rst_n),
        .we      (reg_wr.bank_we[0]),
        .wr_id   (blk.id),
        .wdata   (reg_wr.bank_val),
        .rd_id   (blk.id),
        .rdata   (bank_rd[0])
    );

    // Bank number of page 1 for every block
    block_reg_file #(
        .NUM_BLOCKS  (NUM_BLOCKS),
        .entry_t     (bank_t),
        .RESET_VALUE (bank_t'(0))
    ) bank_p1 (
        .cpu_bus (cpu_bus),
        .rst_n   (rst_n),
        .we      (reg_wr.bank_we[1]),
        .wr_id   (blk.id),
        .wdata   (reg_wr.bank_val),
        .rd_id   (blk.id),
        .rdata   (bank_rd[1])
    );

    // SRAM enable of page 0, a single bit per block
    block_reg_file #(
        .NUM_BLOCKS  (NUM_BLOCKS),
        .entry_t     (logic),
        .RESET_VALUE (1'b0)
    ) sram_p0 (
        .cpu_bus (cpu_bus),
        .rst_n   (rst_n),
        .we      (reg_wr.sram_we[0]),
        .wr_id   (blk.id),
        .wdata   (reg_wr.sram_val),
        .rd_id   (blk.id),
        .rdata   (sram_en_rd[0])
    );

    // SRAM enable of page 1
    block_reg_file #(
        .NUM_BLOCKS  (NUM_BLOCKS),
        .entry_t     (logic),
        .RESET_VALUE (1'b0)
    ) sram_p1 (
        .cpu_bus (cpu_bus),
        .rst_n   (rst_n),
        .we      (reg_wr.sram_we[1]),
        .wr_id   (blk.id),
        .wdata   (reg_wr.sram_val),
        .rd_id   (blk.id),
        .rdata   (sram_en_rd[1])
    );

    // Combinational address translation toward the external memory
    cart_addr_xlate u_xlate (
        .cpu_bus    (cpu_bus),
        .cpu_req    (cpu_req),
        .blk        (blk),
        .cs         (cs),
        .mode_rtype (mode_rtype),
        .bank_rd    (bank_rd),
        .sram_en_rd (sram_en_rd),
        .mem        (mem)
    );

endmodule

// ==== cart_pkg.sv ====
// Shared types, widths and constants for the cartridge mapper, imported by the RTL and testbench
package cart_pkg;

    // CPU side bus widths of the Z80-style memory bus
    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;

    // One 16 KB bank number, and the byte offset inside a 16 KB page
    localparam int BANK_W     = 8;
    localparam int PAGE_OFS_W = 14;

    // Flat external memory address width
    localparam int MEM_ADDR_W = 27;

    // Block descriptor field widths, ROM size is in bytes and SRAM size in KB
    localparam int ROM_SIZE_W  = 25;
    localparam int SRAM_SIZE_W = 16;

    // The mapper window 0x4000-0xBFFF is split into two 16 KB pages
    localparam int NUM_PAGES = 2;

    // Number of cartridge blocks sharing one mapper, and the id width it implies
    localparam int NUM_BLOCKS_DEFAULT = 2;
    localparam int BLOCK_ID_W         = $clog2(NUM_BLOCKS_DEFAULT);

    // Data value that switches the battery SRAM into an ASCII16 page
    localparam logic [DATA_W-1:0] SRAM_ENABLE_CODE = 8'h10;

    // In R-Type mode the lower page always shows this bank
    localparam logic [BANK_W-1:0] RTYPE_FIXED_BANK = 8'h0F;

    // Kind of cartridge in a block
    // Codes above MAPPER_RTYPE are reserved for mapper kinds not handled here
    typedef enum logic [3:0] {
        MAPPER_NONE    = 4'd0,
        MAPPER_ASCII16 = 4'd1,
        MAPPER_RTYPE   = 4'd2
    } mapper_type_e;

    typedef logic [BLOCK_ID_W-1:0] block_id_t;
    typedef logic [BANK_W-1:0]     bank_t;
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    // One CPU bus sample, all strobes are plain levels sampled on the clock
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic              mreq;
        logic              rd;
        logic              wr;
        logic              req;
    } cpu_bus_t;

    // Static description of the cartridge block being accessed
    typedef struct packed {
        mapper_type_e           typ;
        block_id_t              id;
        logic [ROM_SIZE_W-1:0]  rom_size;
        logic [SRAM_SIZE_W-1:0] sram_size;
    } block_info_t;

    // Selects and address toward the external memory
    typedef struct packed {
        logic      sram_cs;
        logic      ram_cs;
        logic      rnw;
        mem_addr_t addr;
    } mapper_out_t;

    // Register write strobes, one bit per page, with the values to load
    typedef struct packed {
        logic [NUM_PAGES-1:0] bank_we;
        logic [NUM_PAGES-1:0] sram_we;
        bank_t                bank_val;
        logic                 sram_val;
    } reg_wr_t;

endpackage

// ==== tb_clock.sv ====
// Free-running testbench clock source, instanced by the mapper testbench to drive the CPU bus clock
`timescale 1ns/1ps

module tb_clock #(
    parameter realtime PERIOD = 40.0
) (
    output logic clk
);

    // Start low so the first rising edge lands half a period into the run
    initial begin
        clk = 1'b0;
    end

    // Toggle every half period for a 50 percent duty cycle
    always begin
        #(PERIOD / 2.0);
        clk = ~clk;
    end

endmodule
